/* build.f */
+incdir+design
design/mips_pkg.sv
design/mips_decoder.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_hazard_unit.sv
design/mips_core.sv
tb/tb_mips.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_mips
FILELIST ?= build.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)

/* tb/tb_mips.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"
`default_nettype none

module tb_mips;

	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 8;
	localparam int MEM_WORDS = 256;

	logic                  clk = 1'b0;
	logic                  rst_n = 1'b0;
	logic [`MIPS_XLEN-1:0] imem_addr;
	logic [`MIPS_XLEN-1:0] imem_data;
	logic [`MIPS_XLEN-1:0] dmem_addr;
	logic [`MIPS_XLEN-1:0] dmem_wdata;
	logic [`MIPS_XLEN-1:0] dmem_rdata;
	logic                  dmem_we;

	logic [31:0] imem [MEM_WORDS];
	logic [31:0] dmem [MEM_WORDS];
	logic [31:0] prog [$];
	logic [31:0] seen_addr [$];
	logic [31:0] seen_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	string       cur_test = "reset";
	integer      seed = 32'h1d1e;
	int          cycles = 0;
	int          total_instr = 0;
	int          tests_started = 0;

	always #4 clk = ~clk;

	mips_core uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_data  (imem_data),
		.dmem_rdata (dmem_rdata),
		.imem_addr  (imem_addr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we)
	);

	// Both memories answer combinationally
	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h0001_0003) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] rtype(input logic [5:0] funct, input int rd, rs, rt, sh);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], funct};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input int rt, rs, imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	// ALU operation that the ISA implies for a word in execute
	function automatic mips_pkg::alu_op_t alu_op_for(input logic [31:0] w);
		if (w[31:26] == 6'h00) begin
			case (w[5:0])
				6'h23: return mips_pkg::ALU_SUB;
				6'h24: return mips_pkg::ALU_AND;
				6'h25: return mips_pkg::ALU_OR;
				6'h2a: return mips_pkg::ALU_SLT;
				6'h00: return mips_pkg::ALU_SLL;
				6'h02: return mips_pkg::ALU_SRL;
				default: return mips_pkg::ALU_ADD;
			endcase
		end
		if (w[31:26] == 6'h0d)
			return mips_pkg::ALU_OR;
		if (w[31:26] == 6'h0f)
			return mips_pkg::ALU_PASS_B;
		return mips_pkg::ALU_ADD;
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, act);
		if (exp !== act) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_reg_addr(input string name, input logic [`MIPS_REG_AW-1:0] exp, act);
		if (exp !== act) begin
			$display("** Error %s: expected dest %0d, actual dest %0d", name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_alu_op(input string name, input mips_pkg::alu_op_t exp, act);
		if (exp !== act) begin
			$display("** Error %s: expected %s, actual %s", name, exp.name(), act.name());
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// Stores seen at the memory-stage strobe also update the data array
	always @(posedge clk) begin
		if (rst_n && dmem_we) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
			seen_addr.push_back(dmem_addr);
			seen_data.push_back(dmem_wdata);
		end
	end

	// Execute-stage controls against the ISA
	always @(negedge clk) begin
		if (rst_n && uut.instr_e != '0) begin
			check_alu_op(cur_test, alu_op_for(uut.instr_e), uut.alu_op_e);
			if (uut.reg_write_e)
				check_reg_addr(cur_test, (uut.instr_e[31:26] == 6'h00) ?
				               uut.instr_e[15:11] : uut.instr_e[20:16], uut.dest_e);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > 3 * total_instr + (RESET_CYCLES + DRAIN_CYCLES) * tests_started) begin
			$display("Timeout in %s after %0d cycles", cur_test, cycles);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	// Architectural model with one delay slot, ends at the self-loop
	task automatic model_run();
		logic [31:0] r [32];
		logic [31:0] mm [int];
		logic [31:0] w;
		logic [31:0] simm;
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nnpc;
		logic [31:0] a;
		int          steps;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		pc = `MIPS_RESET_PC;
		npc = pc + 4;
		steps = 0;
		while (pc != (prog.size() - 2) * 4 && steps < 1000) begin
			w = prog[pc[31:2]];
			simm = {{16{w[15]}}, w[15:0]};
			nnpc = npc + 4;
			case (w[31:26])
				6'h00: begin
					case (w[5:0])
						6'h21: r[w[15:11]] = r[w[25:21]] + r[w[20:16]];
						6'h23: r[w[15:11]] = r[w[25:21]] - r[w[20:16]];
						6'h24: r[w[15:11]] = r[w[25:21]] & r[w[20:16]];
						6'h25: r[w[15:11]] = r[w[25:21]] | r[w[20:16]];
						6'h2a: r[w[15:11]] = {31'd0, $signed(r[w[25:21]]) < $signed(r[w[20:16]])};
						6'h00: r[w[15:11]] = r[w[20:16]] << w[10:6];
						6'h02: r[w[15:11]] = r[w[20:16]] >> w[10:6];
						default: ;
					endcase
				end
				6'h09: r[w[20:16]] = r[w[25:21]] + simm;
				6'h0d: r[w[20:16]] = r[w[25:21]] | {16'h0000, w[15:0]};
				6'h0f: r[w[20:16]] = {w[15:0], 16'h0000};
				6'h23: begin
					a = r[w[25:21]] + simm;
					r[w[20:16]] = mm.exists(a) ? mm[a] : fill_word(a);
				end
				6'h2b: begin
					a = r[w[25:21]] + simm;
					mm[a] = r[w[20:16]];
					exp_addr.push_back(a);
					exp_data.push_back(r[w[20:16]]);
				end
				6'h04: if (r[w[25:21]] == r[w[20:16]]) nnpc = pc + 4 + (simm << 2);
				6'h05: if (r[w[25:21]] != r[w[20:16]]) nnpc = pc + 4 + (simm << 2);
				default: ;
			endcase
			r[0] = '0;
			pc = npc;
			npc = nnpc;
			steps++;
		end
	endtask

	// Loads the program, resets the core, runs to the self-loop and compares stores
	task automatic run_program(input string name, input bit check_start);
		logic [31:0] loop_addr;
		emit(itype(6'h04, 0, 0, -1));
		emit(32'h0000_0000);
		loop_addr = (prog.size() - 2) * 4;
		cur_test = name;
		tests_started++;
		total_instr += prog.size();
		exp_addr.delete();
		exp_data.delete();
		model_run();
		@(posedge clk);
		rst_n <= 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : 32'h0000_0000;
			dmem[i] = fill_word(i * 4);
		end
		seen_addr.delete();
		seen_data.delete();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		if (check_start) begin
			for (int k = 0; k < 4; k++) begin
				@(negedge clk);
				check_word(name, `MIPS_RESET_PC + 4 * k, imem_addr);
				if (dmem_we) begin
					$display("%s: a store strobe appeared right after reset", name);
					$display("TEST FAILED");
					$fatal(1);
				end
			end
		end
		while (imem_addr != loop_addr)
			@(negedge clk);
		repeat (DRAIN_CYCLES - 2) @(negedge clk);
		if (seen_addr.size() != exp_addr.size()) begin
			$display("%s: saw %0d stores where %0d were expected", name,
			         seen_addr.size(), exp_addr.size());
			$display("TEST FAILED");
			$fatal(1);
		end
		for (int i = 0; i < exp_addr.size(); i++) begin
			check_word(name, exp_addr[i], seen_addr[i]);
			check_word(name, exp_data[i], seen_data[i]);
		end
		prog.delete();
	endtask

	task automatic test_alu_ops();
		logic [31:0] a;
		logic [31:0] b;
		a = $random(seed);
		b = $random(seed);
		emit(itype(6'h0f, 1, 0, a[31:16]));
		emit(itype(6'h0d, 1, 1, a[15:0]));
		emit(itype(6'h0f, 2, 0, b[31:16]));
		emit(itype(6'h0d, 2, 2, b[15:0]));
		emit(rtype(6'h21, 3, 1, 2, 0));
		emit(itype(6'h2b, 3, 0, 'h100));
		emit(rtype(6'h23, 4, 1, 2, 0));
		emit(itype(6'h2b, 4, 0, 'h104));
		emit(rtype(6'h24, 5, 1, 2, 0));
		emit(itype(6'h2b, 5, 0, 'h108));
		emit(rtype(6'h25, 6, 1, 2, 0));
		emit(itype(6'h2b, 6, 0, 'h10c));
		emit(rtype(6'h2a, 7, 1, 2, 0));
		emit(itype(6'h2b, 7, 0, 'h110));
		emit(rtype(6'h00, 8, 0, 1, $random(seed) & 31));
		emit(itype(6'h2b, 8, 0, 'h114));
		emit(rtype(6'h02, 9, 0, 2, $random(seed) & 31));
		emit(itype(6'h2b, 9, 0, 'h118));
		emit(itype(6'h09, 10, 1, $random(seed)));
		emit(itype(6'h2b, 10, 0, 'h11c));
		run_program("alu_ops", 1'b1);
	endtask

	task automatic test_forwarding();
		emit(itype(6'h09, 1, 0, 5));
		emit(rtype(6'h21, 2, 1, 1, 0));
		emit(rtype(6'h21, 3, 2, 1, 0));
		emit(itype(6'h2b, 3, 0, 'h180));
		emit(rtype(6'h23, 4, 3, 2, 0));
		emit(32'h0000_0000);
		emit(rtype(6'h21, 5, 4, 3, 0));
		emit(itype(6'h2b, 5, 0, 'h184));
		emit(itype(6'h2b, 4, 0, 'h188));
		run_program("forwarding", 1'b0);
	endtask

	task automatic test_load_use();
		emit(itype(6'h0f, 1, 0, 'h1234));
		emit(itype(6'h0d, 1, 1, 'h5678));
		emit(itype(6'h2b, 1, 0, 'h200));
		emit(itype(6'h23, 2, 0, 'h200));
		emit(rtype(6'h21, 3, 2, 1, 0));
		emit(itype(6'h2b, 3, 0, 'h204));
		emit(itype(6'h23, 4, 0, 'h300));
		emit(rtype(6'h21, 5, 4, 0, 0));
		emit(itype(6'h2b, 5, 0, 'h208));
		run_program("load_use", 1'b0);
	endtask

	task automatic test_branches();
		emit(itype(6'h09, 1, 0, 3));
		emit(itype(6'h09, 2, 0, 3));
		// Operand from the instruction just before
		emit(itype(6'h04, 2, 1, 2));
		emit(itype(6'h2b, 1, 0, 'h400));
		emit(itype(6'h2b, 1, 0, 'h404));
		emit(itype(6'h2b, 2, 0, 'h408));
		emit(itype(6'h05, 2, 1, 2));
		emit(itype(6'h2b, 1, 0, 'h40c));
		emit(itype(6'h2b, 1, 0, 'h410));
		emit(itype(6'h09, 3, 0, 7));
		emit(itype(6'h05, 1, 3, 2));
		emit(itype(6'h2b, 3, 0, 'h414));
		emit(itype(6'h2b, 3, 0, 'h418));
		emit(itype(6'h04, 3, 1, 2));
		emit(itype(6'h2b, 3, 0, 'h41c));
		emit(itype(6'h2b, 3, 0, 'h420));
		// Operand from a load two instructions before
		emit(itype(6'h23, 4, 0, 'h400));
		emit(itype(6'h09, 5, 0, 0));
		emit(itype(6'h04, 1, 4, 2));
		emit(itype(6'h2b, 4, 0, 'h424));
		emit(itype(6'h2b, 4, 0, 'h428));
		emit(itype(6'h2b, 4, 0, 'h42c));
		run_program("branches", 1'b0);
	endtask

	initial begin
		test_alu_ops();
		test_forwarding();
		test_load_use();
		test_branches();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* design/mips_core.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"
`default_nettype none

module mips_core (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire [`MIPS_XLEN-1:0]   imem_data,
	input  wire [`MIPS_XLEN-1:0]   dmem_rdata,
	output logic [`MIPS_XLEN-1:0]  imem_addr,
	output logic [`MIPS_XLEN-1:0]  dmem_addr,
	output logic [`MIPS_XLEN-1:0]  dmem_wdata,
	output logic                   dmem_we
);

	// Fetch
	logic [`MIPS_XLEN-1:0]   pc;
	logic [`MIPS_XLEN-1:0]   pc_plus4;
	logic [`MIPS_XLEN-1:0]   pc_next;

	// Decode
	logic [`MIPS_XLEN-1:0]   instr_d;
	logic [`MIPS_XLEN-1:0]   pc_plus4_d;
	logic [`MIPS_REG_AW-1:0] rs_d;
	logic [`MIPS_REG_AW-1:0] rt_d;
	logic [15:0]             imm16_d;
	logic [`MIPS_XLEN-1:0]   imm_ext_d;
	logic [`MIPS_XLEN-1:0]   branch_target_d;
	logic [`MIPS_XLEN-1:0]   rdata_a_d;
	logic [`MIPS_XLEN-1:0]   rdata_b_d;
	logic [`MIPS_XLEN-1:0]   cmp_a_d;
	logic [`MIPS_XLEN-1:0]   cmp_b_d;
	logic                    branch_d;
	logic                    branch_taken_d;
	mips_pkg::alu_op_t       alu_op_d;
	mips_pkg::imm_kind_t     imm_kind_d;
	logic                    alu_src_imm_d;
	logic                    shift_by_shamt_d;
	logic                    reg_write_d;
	logic [`MIPS_REG_AW-1:0] dest_d;
	logic                    mem_read_d;
	logic                    mem_write_d;
	logic                    branch_eq_d;
	logic                    branch_ne_d;
	logic                    uses_rs_d;
	logic                    uses_rt_d;

	// Execute
	logic [`MIPS_XLEN-1:0]   instr_e;
	logic [`MIPS_XLEN-1:0]   rdata_a_e;
	logic [`MIPS_XLEN-1:0]   rdata_b_e;
	logic [`MIPS_XLEN-1:0]   imm_e;
	mips_pkg::alu_op_t       alu_op_e;
	logic                    alu_src_imm_e;
	logic                    shift_by_shamt_e;
	logic                    reg_write_e;
	logic [`MIPS_REG_AW-1:0] dest_e;
	logic                    mem_read_e;
	logic                    mem_write_e;
	logic [`MIPS_REG_AW-1:0] rs_e;
	logic [`MIPS_REG_AW-1:0] rt_e;
	logic [`MIPS_XLEN-1:0]   src_a_e;
	logic [`MIPS_XLEN-1:0]   src_b_e;
	logic [`MIPS_XLEN-1:0]   alu_b_e;
	logic [4:0]              alu_shamt_e;
	logic [`MIPS_XLEN-1:0]   alu_result_e;

	// Memory
	logic [`MIPS_XLEN-1:0]   alu_out_m;
	logic [`MIPS_XLEN-1:0]   store_data_m;
	logic                    reg_write_m;
	logic [`MIPS_REG_AW-1:0] dest_m;
	logic                    mem_read_m;
	logic                    mem_write_m;

	// Write-back
	logic [`MIPS_XLEN-1:0]   alu_out_w;
	logic [`MIPS_XLEN-1:0]   load_data_w;
	logic                    reg_write_w;
	logic [`MIPS_REG_AW-1:0] dest_w;
	logic                    mem_read_w;
	logic [`MIPS_XLEN-1:0]   wb_data_w;

	mips_pkg::fwd_sel_t      fwd_a_e;
	mips_pkg::fwd_sel_t      fwd_b_e;
	mips_pkg::fwd_sel_t      fwd_a_d;
	mips_pkg::fwd_sel_t      fwd_b_d;
	logic                    stall;

	function automatic logic [`MIPS_XLEN-1:0] fwd_pick(
		input mips_pkg::fwd_sel_t    sel,
		input logic [`MIPS_XLEN-1:0] reg_val,
		input logic [`MIPS_XLEN-1:0] from_m,
		input logic [`MIPS_XLEN-1:0] from_w
	);
		case (sel)
			mips_pkg::FWD_FROM_M: return from_m;
			mips_pkg::FWD_FROM_W: return from_w;
			default:              return reg_val;
		endcase
	endfunction

	// Branch resolves in decode while its delay slot is being fetched
	assign pc_plus4  = pc + 4;
	assign pc_next   = branch_taken_d ? branch_target_d : pc_plus4;
	assign imem_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= `MIPS_RESET_PC;
			instr_d <= `MIPS_NOP;
		end else if (!stall) begin
			pc      <= pc_next;
			instr_d <= imem_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			pc_plus4_d <= pc_plus4;
		end
	end

	assign rs_d    = instr_d[25:21];
	assign rt_d    = instr_d[20:16];
	assign imm16_d = instr_d[15:0];

	mips_decoder u_decoder (
		.instr          (instr_d),
		.alu_op         (alu_op_d),
		.imm_kind       (imm_kind_d),
		.alu_src_imm    (alu_src_imm_d),
		.shift_by_shamt (shift_by_shamt_d),
		.reg_write      (reg_write_d),
		.dest           (dest_d),
		.mem_read       (mem_read_d),
		.mem_write      (mem_write_d),
		.branch_eq      (branch_eq_d),
		.branch_ne      (branch_ne_d),
		.uses_rs        (uses_rs_d),
		.uses_rt        (uses_rt_d)
	);

	mips_regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.we      (reg_write_w),
		.waddr   (dest_w),
		.wdata   (wb_data_w),
		.raddr_a (rs_d),
		.raddr_b (rt_d),
		.rdata_a (rdata_a_d),
		.rdata_b (rdata_b_d)
	);

	always_comb begin
		case (imm_kind_d)
			mips_pkg::IMM_ZERO:
				imm_ext_d = {{(`MIPS_XLEN-16){1'b0}}, imm16_d};
			mips_pkg::IMM_UPPER:
				imm_ext_d = {imm16_d, {(`MIPS_XLEN-16){1'b0}}};
			default:
				imm_ext_d = {{(`MIPS_XLEN-16){imm16_d[15]}}, imm16_d};
		endcase
	end

	assign branch_target_d = pc_plus4_d + {{(`MIPS_XLEN-18){imm16_d[15]}}, imm16_d, 2'b00};

	// Decode compare only ever forwards from memory
	assign cmp_a_d        = (fwd_a_d == mips_pkg::FWD_FROM_M) ? alu_out_m : rdata_a_d;
	assign cmp_b_d        = (fwd_b_d == mips_pkg::FWD_FROM_M) ? alu_out_m : rdata_b_d;
	assign branch_d       = branch_eq_d || branch_ne_d;
	assign branch_taken_d = (branch_eq_d && cmp_a_d == cmp_b_d) ||
	                        (branch_ne_d && cmp_a_d != cmp_b_d);

	// A stall sends a bubble into execute
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_e          <= `MIPS_NOP;
			alu_op_e         <= mips_pkg::ALU_ADD;
			alu_src_imm_e    <= 1'b0;
			shift_by_shamt_e <= 1'b0;
			reg_write_e      <= 1'b0;
			dest_e           <= '0;
			mem_read_e       <= 1'b0;
			mem_write_e      <= 1'b0;
		end else begin
			instr_e          <= stall ? `MIPS_NOP : instr_d;
			alu_op_e         <= stall ? mips_pkg::ALU_ADD : alu_op_d;
			alu_src_imm_e    <= alu_src_imm_d && !stall;
			shift_by_shamt_e <= shift_by_shamt_d && !stall;
			reg_write_e      <= reg_write_d && !stall;
			dest_e           <= stall ? '0 : dest_d;
			mem_read_e       <= mem_read_d && !stall;
			mem_write_e      <= mem_write_d && !stall;
		end
	end

	always_ff @(posedge clk) begin
		rdata_a_e <= rdata_a_d;
		rdata_b_e <= rdata_b_d;
		imm_e     <= imm_ext_d;
	end

	assign rs_e        = instr_e[25:21];
	assign rt_e        = instr_e[20:16];
	assign src_a_e     = fwd_pick(fwd_a_e, rdata_a_e, alu_out_m, wb_data_w);
	assign src_b_e     = fwd_pick(fwd_b_e, rdata_b_e, alu_out_m, wb_data_w);
	assign alu_b_e     = alu_src_imm_e ? imm_e : src_b_e;
	assign alu_shamt_e = shift_by_shamt_e ? instr_e[10:6] : 5'd0;

	mips_alu u_alu (
		.op     (alu_op_e),
		.a      (src_a_e),
		.b      (alu_b_e),
		.shamt  (alu_shamt_e),
		.result (alu_result_e)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_write_m <= 1'b0;
			dest_m      <= '0;
			mem_read_m  <= 1'b0;
			mem_write_m <= 1'b0;
			reg_write_w <= 1'b0;
			dest_w      <= '0;
			mem_read_w  <= 1'b0;
		end else begin
			reg_write_m <= reg_write_e;
			dest_m      <= dest_e;
			mem_read_m  <= mem_read_e;
			mem_write_m <= mem_write_e;
			reg_write_w <= reg_write_m;
			dest_w      <= dest_m;
			mem_read_w  <= mem_read_m;
		end
	end

	// Store data is the forwarded rt
	always_ff @(posedge clk) begin
		alu_out_m    <= alu_result_e;
		store_data_m <= src_b_e;
		alu_out_w    <= alu_out_m;
		load_data_w  <= dmem_rdata;
	end

	assign dmem_addr  = alu_out_m;
	assign dmem_wdata = store_data_m;
	assign dmem_we    = mem_write_m;
	assign wb_data_w  = mem_read_w ? load_data_w : alu_out_w;

	mips_hazard_unit u_hazard (
		.rs_d        (rs_d),
		.rt_d        (rt_d),
		.uses_rs_d   (uses_rs_d),
		.uses_rt_d   (uses_rt_d),
		.branch_d    (branch_d),
		.rs_e        (rs_e),
		.rt_e        (rt_e),
		.dest_e      (dest_e),
		.reg_write_e (reg_write_e),
		.mem_read_e  (mem_read_e),
		.dest_m      (dest_m),
		.reg_write_m (reg_write_m),
		.mem_read_m  (mem_read_m),
		.dest_w      (dest_w),
		.reg_write_w (reg_write_w),
		.fwd_a_e     (fwd_a_e),
		.fwd_b_e     (fwd_b_e),
		.fwd_a_d     (fwd_a_d),
		.fwd_b_d     (fwd_b_d),
		.stall       (stall)
	);

	// Load data reaches the branch compare only through the regfile bypass
	a_no_load_fwd_d: assert property (@(posedge clk) disable iff (!rst_n)
		(branch_d && mem_read_m && reg_write_m &&
		 ((uses_rs_d && rs_d == dest_m) || (uses_rt_d && rt_d == dest_m))) |-> stall);

endmodule

`default_nettype wire

/* design/mips_hazard_unit.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"
`default_nettype none

module mips_hazard_unit (
	input  wire [`MIPS_REG_AW-1:0]  rs_d,
	input  wire [`MIPS_REG_AW-1:0]  rt_d,
	input  wire                     uses_rs_d,
	input  wire                     uses_rt_d,
	input  wire                     branch_d,
	input  wire [`MIPS_REG_AW-1:0]  rs_e,
	input  wire [`MIPS_REG_AW-1:0]  rt_e,
	input  wire [`MIPS_REG_AW-1:0]  dest_e,
	input  wire                     reg_write_e,
	input  wire                     mem_read_e,
	input  wire [`MIPS_REG_AW-1:0]  dest_m,
	input  wire                     reg_write_m,
	input  wire                     mem_read_m,
	input  wire [`MIPS_REG_AW-1:0]  dest_w,
	input  wire                     reg_write_w,
	output mips_pkg::fwd_sel_t      fwd_a_e,
	output mips_pkg::fwd_sel_t      fwd_b_e,
	output mips_pkg::fwd_sel_t      fwd_a_d,
	output mips_pkg::fwd_sel_t      fwd_b_d,
	output logic                    stall
);

	logic load_use;
	logic branch_wait;

	// Youngest producer wins
	function automatic mips_pkg::fwd_sel_t pick_e(input logic [`MIPS_REG_AW-1:0] src);
		if (reg_write_m && dest_m == src)
			return mips_pkg::FWD_FROM_M;
		else if (reg_write_w && dest_w == src)
			return mips_pkg::FWD_FROM_W;
		return mips_pkg::FWD_REG;
	endfunction

	// Write-back is covered by the regfile bypass, load data is not ready yet
	function automatic mips_pkg::fwd_sel_t pick_d(input logic [`MIPS_REG_AW-1:0] src);
		if (reg_write_m && !mem_read_m && dest_m == src)
			return mips_pkg::FWD_FROM_M;
		return mips_pkg::FWD_REG;
	endfunction

	function automatic logic reads_reg(input logic [`MIPS_REG_AW-1:0] dest);
		return (uses_rs_d && rs_d == dest) || (uses_rt_d && rt_d == dest);
	endfunction

	always_comb begin
		fwd_a_e = pick_e(rs_e);
		fwd_b_e = pick_e(rt_e);
		fwd_a_d = pick_d(rs_d);
		fwd_b_d = pick_d(rt_d);
	end

	always_comb begin
		load_use    = mem_read_e && reg_write_e && reads_reg(dest_e);
		// Branch compares in decode, so an ALU result one stage ahead is too late
		branch_wait = branch_d &&
		              ((reg_write_e && reads_reg(dest_e)) ||
		               (mem_read_m && reg_write_m && reads_reg(dest_m)));
		stall       = load_use || branch_wait;
	end

endmodule

`default_nettype wire

/* design/mips_alu.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"
`default_nettype none

module mips_alu (
	input  wire mips_pkg::alu_op_t  op,
	input  wire [`MIPS_XLEN-1:0]    a,
	input  wire [`MIPS_XLEN-1:0]    b,
	input  wire [4:0]               shamt,
	output logic [`MIPS_XLEN-1:0]   result
);

	logic less;

	// Signed compare for slt
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD:
				result = a + b;
			mips_pkg::ALU_SUB:
				result = a - b;
			mips_pkg::ALU_AND:
				result = a & b;
			mips_pkg::ALU_OR:
				result = a | b;
			mips_pkg::ALU_SLT:
				result = {{(`MIPS_XLEN-1){1'b0}}, less};
			mips_pkg::ALU_SLL:
				result = b << shamt;
			mips_pkg::ALU_SRL:
				result = b >> shamt;
			// lui arrives already shifted into the upper half
			default:
				result = b;
		endcase
	end

endmodule

`default_nettype wire

/* design/mips_regfile.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"
`default_nettype none

module mips_regfile (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     we,
	input  wire [`MIPS_REG_AW-1:0]  waddr,
	input  wire [`MIPS_XLEN-1:0]    wdata,
	input  wire [`MIPS_REG_AW-1:0]  raddr_a,
	input  wire [`MIPS_REG_AW-1:0]  raddr_b,
	output logic [`MIPS_XLEN-1:0]   rdata_a,
	output logic [`MIPS_XLEN-1:0]   rdata_b
);

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-through so decode sees the value retiring in write-back
	assign rdata_a = (raddr_a == '0) ? '0 :
	                 (we && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (raddr_b == '0) ? '0 :
	                 (we && waddr == raddr_b) ? wdata : regs[raddr_b];

	// Decoder drops reg_write for $0, so no write-back ever targets it
	a_no_write_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!(we && waddr == '0));

endmodule

`default_nettype wire

/* design/mips_decoder.sv */
`timescale 1ns/100ps
`include "mips_macros.svh"
`default_nettype none

module mips_decoder (
	input  wire [`MIPS_XLEN-1:0]    instr,
	output mips_pkg::alu_op_t       alu_op,
	output mips_pkg::imm_kind_t     imm_kind,
	output logic                    alu_src_imm,
	output logic                    shift_by_shamt,
	output logic                    reg_write,
	output logic [`MIPS_REG_AW-1:0] dest,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic                    branch_eq,
	output logic                    branch_ne,
	output logic                    uses_rs,
	output logic                    uses_rt
);

	mips_pkg::opcode_t       opcode;
	mips_pkg::funct_t        funct;
	logic [`MIPS_REG_AW-1:0] rt;
	logic [`MIPS_REG_AW-1:0] rd;
	logic                    writes;

	assign opcode = mips_pkg::opcode_t'(instr[31:26]);
	assign funct  = mips_pkg::funct_t'(instr[5:0]);
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	always_comb begin
		alu_op         = mips_pkg::ALU_ADD;
		imm_kind       = mips_pkg::IMM_SIGN;
		alu_src_imm    = 1'b0;
		shift_by_shamt = 1'b0;
		writes         = 1'b0;
		dest           = rt;
		mem_read       = 1'b0;
		mem_write      = 1'b0;
		branch_eq      = 1'b0;
		branch_ne      = 1'b0;
		uses_rs        = 1'b0;
		uses_rt        = 1'b0;
		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				dest    = rd;
				writes  = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				case (funct)
					mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLL,
					mips_pkg::FN_SRL: begin
						// Shift rt by the shamt field, rs is not read
						alu_op         = (funct == mips_pkg::FN_SLL) ?
						                 mips_pkg::ALU_SLL : mips_pkg::ALU_SRL;
						shift_by_shamt = 1'b1;
						uses_rs        = 1'b0;
					end
					default: begin
						writes  = 1'b0;
						uses_rs = 1'b0;
						uses_rt = 1'b0;
					end
				endcase
			end
			mips_pkg::OP_ADDIU: begin
				alu_src_imm = 1'b1;
				writes      = 1'b1;
				uses_rs     = 1'b1;
			end
			mips_pkg::OP_ORI: begin
				alu_op      = mips_pkg::ALU_OR;
				imm_kind    = mips_pkg::IMM_ZERO;
				alu_src_imm = 1'b1;
				writes      = 1'b1;
				uses_rs     = 1'b1;
			end
			mips_pkg::OP_LUI: begin
				alu_op      = mips_pkg::ALU_PASS_B;
				imm_kind    = mips_pkg::IMM_UPPER;
				alu_src_imm = 1'b1;
				writes      = 1'b1;
			end
			mips_pkg::OP_LW: begin
				alu_src_imm = 1'b1;
				writes      = 1'b1;
				mem_read    = 1'b1;
				uses_rs     = 1'b1;
			end
			mips_pkg::OP_SW: begin
				// rt is the store data
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
				uses_rs     = 1'b1;
				uses_rt     = 1'b1;
			end
			mips_pkg::OP_BEQ,
			mips_pkg::OP_BNE: begin
				branch_eq = (opcode == mips_pkg::OP_BEQ);
				branch_ne = (opcode == mips_pkg::OP_BNE);
				uses_rs   = 1'b1;
				uses_rt   = 1'b1;
			end
			default: ;
		endcase
	end

	// $0 is never a real destination, so nothing forwards from it
	assign reg_write = writes && (dest != '0);

endmodule

`default_nettype wire

/* design/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	// Function field of SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_t;

	// How the 16-bit immediate is widened
	typedef enum logic [1:0] {
		IMM_SIGN,
		IMM_ZERO,
		IMM_UPPER
	} imm_kind_t;

	// Operand source for the execute ALU and the decode compare
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_FROM_M,
		FWD_FROM_W
	} fwd_sel_t;

endpackage

`default_nettype wire

/* design/mips_macros.svh */
`default_nettype none

`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Data path and address width
`define MIPS_XLEN 32

// Register file addressing
`define MIPS_REG_AW 5
`define MIPS_NREGS 32

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// sll $0,$0,0, used as the bubble word in the stage registers
`define MIPS_NOP 32'h0000_0000

`endif

`default_nettype wire
